// ==== sources.f ====
hdl/rv32i_mem_pkg.sv
hdl/dmem_extender.sv
hdl/load_store_unit.sv
hdl/fetch_unit.sv
hdl/mem_arbiter.sv
hdl/word_ram.sv
hdl/mem_subsystem_top.sv
tb/tb_clock_gen.sv
tb/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run the testbench, then look for the fail message in the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mem_subsystem \
  -f sources.f -o sim_mem_subsystem || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_mem_subsystem > sim.log 2>&1 || { cat sim.log; echo "Simulator exited with an error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
echo "Simulation PASSED"

// ==== tb/tb_mem_subsystem.sv ====
// Memory subsystem testbench with shadow byte model, concurrent checks, timeout and report.
`default_nettype none

module tb_mem_subsystem import rv32i_mem_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 4000; // About twice the length of the whole sequence.

  logic   clk, rst_n, ld_req, st_req, fetch_en;
  addr_t  addr, instr_pc;
  load_t  load_type;
  store_t store_type;
  word_t  store_data, ld_data, instr;
  logic   ld_done, st_done, misaligned, busy, instr_valid;

  logic [7:0] shadow [1024]; // RAM image, one byte per address, little-endian.
  logic  exp_bad;            // The request on the bus is misaligned.
  word_t exp_ld;             // Value the current load has to return.
  addr_t req_addr;           // Address of the current request.
  addr_t exp_pc;             // PC that the next returning instruction must carry.
  word_t exp_instr;          // Shadow word at exp_pc in memory byte order.
  int    seed = 32'h96b9;
  int    value_errs = 0;
  int    other_errs = 0;
  int    fetch_count = 0;
  int    cycles = 0;

  tb_clock_gen u_clock_gen (.clk(clk));

  mem_subsystem_top dut (
    .clk, .rst_n, .ld_req, .st_req, .addr, .load_type, .store_type, .store_data,
    .ld_data, .ld_done, .st_done, .misaligned, .busy,
    .fetch_en, .instr, .instr_pc, .instr_valid
  );

  // ############################
  // Shadow model.
  // ############################

  // Load result straight from the byte image: slice, then sign or zero extend.
  function automatic word_t expected_load(load_t lt, addr_t a);
    logic [9:0]  b;
    logic [15:0] half_v;
    b      = a[9:0];
    half_v = {shadow[b + 10'd1], shadow[b]};
    case (lt)
      LB:      expected_load = {{24{shadow[b][7]}}, shadow[b]};
      LBU:     expected_load = {24'h0, shadow[b]};
      LH:      expected_load = {{16{half_v[15]}}, half_v};
      LHU:     expected_load = {16'h0, half_v};
      default: expected_load = {shadow[b + 10'd3], shadow[b + 10'd2], half_v};
    endcase
  endfunction

  // Initial RAM contents; every address bit changes the word.
  function automatic word_t fill_word(addr_t a);
    fill_word = {~a[15:0], a[15:0]} ^ 32'h3c5a_96e1;
  endfunction

  // Instructions come back big-endian. The lowest address sits in the top byte.
  always_comb begin
    exp_instr = {shadow[{exp_pc[9:2], 2'd0}], shadow[{exp_pc[9:2], 2'd1}],
                 shadow[{exp_pc[9:2], 2'd2}], shadow[{exp_pc[9:2], 2'd3}]};
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc <= RESET_PC;
    end else if (instr_valid) begin
      exp_pc      <= exp_pc + 32'd4; // Strict order, one word per return.
      fetch_count <= fetch_count + 1;
    end
  end

  // ############################
  // Checks.
  // ############################

  ld_done_chk: assert property (@(posedge clk) disable iff (!rst_n)
      (ld_req && !exp_bad) |=> (ld_done && !misaligned))
    else begin
      other_errs++;
      $display("%0t: load at %h did not finish with ld_done one cycle later",
               $time, $sampled(req_addr));
    end

  ld_data_chk: assert property (@(posedge clk) disable iff (!rst_n)
      (ld_req && !exp_bad) |=> (ld_data == exp_ld))
    else begin
      value_errs++;
      $display("[ERROR] %0t ld_data expected %h actual %h", $time, $sampled(exp_ld),
               $sampled(ld_data));
    end

  st_done_chk: assert property (@(posedge clk) disable iff (!rst_n)
      (st_req && !exp_bad) |=> (st_done && !misaligned))
    else begin
      other_errs++;
      $display("%0t: store at %h did not raise st_done one cycle later",
               $time, $sampled(req_addr));
    end

  // A misaligned access is flagged and completes nothing else.
  misaligned_chk: assert property (@(posedge clk) disable iff (!rst_n)
      ((ld_req || st_req) && exp_bad) |=> (misaligned && !ld_done && !st_done))
    else begin
      other_errs++;
      $display("%0t: misaligned access at %h was not flagged alone one cycle later",
               $time, $sampled(req_addr));
    end

  idle_chk: assert property (@(posedge clk) disable iff (!rst_n)
      !(ld_req || st_req) |=> !(ld_done || st_done || misaligned))
    else begin
      other_errs++;
      $display("%0t: a completion strobe rose without a request before it", $time);
    end

  busy_chk: assert property (@(posedge clk) disable iff (!rst_n)
      (ld_req || st_req) |=> busy)
    else begin
      other_errs++;
      $display("%0t: busy stayed low in the cycle after a request", $time);
    end

  pc_chk: assert property (@(posedge clk) disable iff (!rst_n)
      instr_valid |-> (instr_pc == exp_pc))
    else begin
      value_errs++;
      $display("[ERROR] %0t instr_pc expected %h actual %h", $time, $sampled(exp_pc),
               $sampled(instr_pc));
    end

  instr_chk: assert property (@(posedge clk) disable iff (!rst_n)
      instr_valid |-> (instr == exp_instr))
    else begin
      value_errs++;
      $display("[ERROR] %0t instr expected %h actual %h", $time, $sampled(exp_instr),
               $sampled(instr));
    end

  // ############################
  // Stimulus.
  // ############################

  // One store, then the completion cycle. The shadow follows the RAM write edge.
  task automatic store_access(store_t st, addr_t a, word_t d);
    logic [1:0] mask; // Low address bits that must be clear for this size.
    logic       bad;
    mask = (st == SW) ? 2'b11 : (st == SH) ? 2'b01 : 2'b00;
    bad  = (a[1:0] & mask) != 2'b00;
    @(posedge clk);
    st_req     <= 1'b1;
    addr       <= a;
    store_type <= st;
    store_data <= d;
    exp_bad    <= bad;
    req_addr   <= a;
    @(posedge clk);
    st_req <= 1'b0;
    if (!bad) begin
      shadow[a[9:0]] <= d[7:0];
      if (st != SB) begin
        shadow[a[9:0] + 10'd1] <= d[15:8];
      end
      if (st == SW) begin
        shadow[a[9:0] + 10'd2] <= d[23:16];
        shadow[a[9:0] + 10'd3] <= d[31:24];
      end
    end
  endtask

  task automatic load_access(load_t lt, addr_t a);
    logic [1:0] mask;
    mask = (lt == LW) ? 2'b11 : (lt == LH || lt == LHU) ? 2'b01 : 2'b00;
    @(posedge clk);
    ld_req    <= 1'b1;
    addr      <= a;
    load_type <= lt;
    exp_bad   <= (a[1:0] & mask) != 2'b00;
    exp_ld    <= expected_load(lt, a);
    req_addr  <= a;
    @(posedge clk);
    ld_req <= 1'b0;
  endtask

  initial begin
    word_t r, a, d;
    int    total_other;
    rst_n      = 1'b0;
    ld_req     = 1'b0;
    st_req     = 1'b0;
    fetch_en   = 1'b0;
    addr       = '0;
    load_type  = LW;
    store_type = SW;
    store_data = '0;
    exp_bad    = 1'b0;
    exp_ld     = '0;
    req_addr   = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < RAM_WORDS; i++) begin
      store_access(SW, i * 4, fill_word(i * 4)); // Whole RAM known before fetch starts.
    end
    fetch_en <= 1'b1; // Fetch runs under every data access from here on.

    repeat (40) begin
      a = $random(seed);
      d = $random(seed);
      a[1:0] = 2'b00;
      store_access(SW, a, d);
      load_access(LW, a);
    end

    // Byte and half loads at every offset of a fresh random word.
    repeat (16) begin
      a = $random(seed);
      a[1:0] = 2'b00;
      store_access(SW, a, $random(seed));
      for (int off = 0; off < 4; off++) begin
        load_access(LB, a + off);
        load_access(LBU, a + off);
      end
      for (int off = 0; off < 4; off += 2) begin
        load_access(LH, a + off);
        load_access(LHU, a + off);
      end
    end

    repeat (60) begin
      r = $random(seed);
      a = $random(seed);
      d = $random(seed);
      if (r[0]) begin
        store_access(SH, {a[31:1], 1'b0}, d);
      end else begin
        store_access(SB, a, d);
      end
      load_access(LW, {a[31:2], 2'b00}); // Neighbour bytes must survive.
    end

    repeat (10) begin
      a = $random(seed);
      d = $random(seed);
      a[0] = 1'b1; // Odd address, wrong for halves and words.
      load_access(LH, a);
      load_access(LHU, a);
      load_access(LW, {a[31:2], 2'b10});
      store_access(SH, a, d);
      store_access(SW, {a[31:2], 2'b10}, d);
      load_access(LW, {a[31:2], 2'b00});
    end

    // Mixed traffic with random gaps so fetch stalls at varying points.
    repeat (100) begin
      r = $random(seed);
      a = $random(seed);
      d = $random(seed);
      case (r[2:0])
        3'd0:    store_access(SW, {a[31:2], 2'b00}, d);
        3'd1:    store_access(SH, {a[31:1], 1'b0}, d);
        3'd2:    store_access(SB, a, d);
        3'd3:    load_access(LW, {a[31:2], 2'b00});
        3'd4:    load_access(r[3] ? LH : LHU, {a[31:1], 1'b0});
        default: load_access(r[3] ? LB : LBU, a);
      endcase
      repeat (r[5:4]) @(posedge clk);
    end

    fetch_en <= 1'b0;
    repeat (3) @(posedge clk); // Let the last fetch return and be checked.
    total_other = other_errs;
    if (fetch_count < 100) begin
      total_other++;
      $display("Fetch returned only %0d instructions while it was enabled", fetch_count);
    end
    $display("Checks done with %0d value errors and %0d other errors", value_errs, total_other);
    if (value_errs == 0 && total_other == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Run stopped by timeout after %0d cycles", cycles);
      $display("Checks done with %0d value errors and %0d other errors", value_errs, other_errs);
      $display("Test failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
// Free-running testbench clock with a period of 20 time units.
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  localparam int HALF_PERIOD = 10; // Half of the 20 unit period.

  initial clk = 1'b0;               // Start low so the first edge is a rising one.
  always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// ==== hdl/mem_subsystem_top.sv ====
// Memory subsystem top: fetch unit, load/store unit, arbiter and word RAM.
`default_nettype none

module mem_subsystem_top import rv32i_mem_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   ld_req,
  input  logic   st_req,
  input  addr_t  addr,
  input  load_t  load_type,
  input  store_t store_type,
  input  word_t  store_data,
  output word_t  ld_data,
  output logic   ld_done,
  output logic   st_done,
  output logic   misaligned,
  output logic   busy,
  input  logic   fetch_en,
  output word_t  instr,
  output addr_t  instr_pc,
  output logic   instr_valid
);

  // Data side to arbiter.
  logic     data_req, data_we, data_gnt, data_rvalid;
  addr_t    data_addr;
  byte_en_t data_be;
  word_t    data_wdata;

  // Fetch side to arbiter.
  logic     fetch_req, fetch_gnt, fetch_rvalid;
  addr_t    fetch_addr;

  // Arbiter to RAM, read data fans out to both clients.
  logic                 ram_en, ram_we;
  byte_en_t             ram_be;
  logic [RAM_IDX_W-1:0] ram_idx;
  word_t                ram_wdata, ram_rdata;

  fetch_unit u_fetch_unit (
    .clk, .rst_n, .fetch_en, .fetch_gnt, .fetch_rvalid, .ram_rdata,
    .fetch_req, .fetch_addr, .instr, .instr_pc, .instr_valid
  );

  load_store_unit u_load_store_unit (
    .clk, .rst_n, .ld_req, .st_req, .addr, .load_type, .store_type, .store_data,
    .data_gnt, .data_rvalid, .ram_rdata,
    .data_req, .data_addr, .data_we, .data_be, .data_wdata,
    .ld_data, .ld_done, .st_done, .misaligned, .busy
  );

  mem_arbiter u_mem_arbiter (
    .clk, .rst_n, .data_req, .data_we, .data_addr, .data_be, .data_wdata,
    .fetch_req, .fetch_addr, .data_gnt, .fetch_gnt, .data_rvalid, .fetch_rvalid,
    .ram_en, .ram_we, .ram_be, .ram_idx, .ram_wdata
  );

  word_ram u_word_ram (
    .clk, .ram_en, .ram_we, .ram_be, .ram_idx, .ram_wdata, .ram_rdata
  );

endmodule

`default_nettype wire

// ==== hdl/word_ram.sv ====
// Single-port word RAM with byte write enables and registered read data.
`default_nettype none

module word_ram import rv32i_mem_pkg::*; (
  input  logic                 clk,
  input  logic                 ram_en,
  input  logic                 ram_we,
  input  byte_en_t             ram_be,
  input  logic [RAM_IDX_W-1:0] ram_idx,
  input  word_t                ram_wdata,
  output word_t                ram_rdata
);

  word_t mem [RAM_WORDS];  // Storage, one word per index.
  word_t rdata_q;          // Read register, holds until the next read.

  // Writes touch only the enabled byte lanes. A read loads the output
  // register, and a write leaves it as it was.
  always_ff @(posedge clk) begin
    if (ram_en) begin
      if (ram_we) begin
        for (int b = 0; b < 4; b++) begin
          if (ram_be[b]) begin
            mem[ram_idx][8*b +: 8] <= ram_wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[ram_idx];
      end
    end
  end

  assign ram_rdata = rdata_q; // Valid the cycle after the read.

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
// Fixed-priority RAM arbiter with data-first grant and registered read return strobes.
`default_nettype none

module mem_arbiter import rv32i_mem_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 data_req,
  input  logic                 data_we,
  input  addr_t                data_addr,
  input  byte_en_t             data_be,
  input  word_t                data_wdata,
  input  logic                 fetch_req,
  input  addr_t                fetch_addr,
  output logic                 data_gnt,
  output logic                 fetch_gnt,
  output logic                 data_rvalid,
  output logic                 fetch_rvalid,
  output logic                 ram_en,
  output logic                 ram_we,
  output byte_en_t             ram_be,
  output logic [RAM_IDX_W-1:0] ram_idx,
  output word_t                ram_wdata
);

  logic data_rd_q;  // Word returning next cycle was read for the data side.
  logic fetch_rd_q; // Word returning next cycle was read for fetch.

  // ############################
  // Grant.
  // ############################

  // Data accesses always win; fetch only gets the idle cycles.
  assign data_gnt  = data_req;
  assign fetch_gnt = fetch_req && !data_req;

  // ############################
  // RAM port mux.
  // ############################

  always_comb begin
    ram_en    = data_req || fetch_req;
    ram_we    = 1'b0;
    ram_be    = '0;
    ram_wdata = data_wdata; // Only the data side ever writes.
    ram_idx   = fetch_addr[RAM_IDX_W+1:2];
    if (data_req) begin
      ram_we  = data_we;
      ram_be  = data_be;
      ram_idx = data_addr[RAM_IDX_W+1:2]; // Word index, byte offset dropped.
    end
  end

  // ############################
  // Read ownership.
  // ############################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_rd_q  <= 1'b0;
      fetch_rd_q <= 1'b0;
    end else begin
      data_rd_q  <= data_gnt && !data_we; // A write returns nothing.
      fetch_rd_q <= fetch_gnt;
    end
  end

  assign data_rvalid  = data_rd_q;
  assign fetch_rvalid = fetch_rd_q;

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
// Sequential instruction fetcher with grant-driven PC and in-flight address tracking.
`default_nettype none

module fetch_unit import rv32i_mem_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  fetch_en,
  input  logic  fetch_gnt,
  input  logic  fetch_rvalid,
  input  word_t ram_rdata,
  output logic  fetch_req,
  output addr_t fetch_addr,
  output word_t instr,
  output addr_t instr_pc,
  output logic  instr_valid
);

  addr_t pc_q;       // Address of the next fetch to issue.
  addr_t inflight_q; // Address of the fetch whose data returns next.
  logic  issue;      // Request accepted by the arbiter this cycle.

  // The request stays up as long as fetching is enabled. The PC only
  // moves on a grant, so a stalled request is simply repeated.
  assign fetch_req  = fetch_en;
  assign fetch_addr = pc_q;
  assign issue      = fetch_req && fetch_gnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (issue) begin
      pc_q <= pc_q + 32'd4; // Straight-line fetch, no redirects.
    end
  end

  // Remember what was issued so the return can be labelled with its PC.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inflight_q <= RESET_PC;
    end else if (issue) begin
      inflight_q <= pc_q;
    end
  end

  // Raw RAM word, still in memory byte order.
  assign instr       = ram_rdata;
  assign instr_pc    = inflight_q;
  assign instr_valid = fetch_rvalid; // Arbiter already tags the owner.

endmodule

`default_nettype wire

// ==== hdl/load_store_unit.sv ====
// Load/store unit: alignment check, lane mask, store formatting and pending load tracking.
`default_nettype none

module load_store_unit import rv32i_mem_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     ld_req,
  input  logic     st_req,
  input  addr_t    addr,
  input  load_t    load_type,
  input  store_t   store_type,
  input  word_t    store_data,
  input  logic     data_gnt,
  input  logic     data_rvalid,
  input  word_t    ram_rdata,
  output logic     data_req,
  output addr_t    data_addr,
  output logic     data_we,
  output byte_en_t data_be,
  output word_t    data_wdata,
  output word_t    ld_data,
  output logic     ld_done,
  output logic     st_done,
  output logic     misaligned,
  output logic     busy
);

  logic     is_half;      // Access moves two bytes.
  logic     is_word;      // Access moves four bytes.
  logic     bad_align;    // Address does not suit the access size.
  logic     accept;       // Aligned request that goes to memory.
  byte_en_t le_be;        // Lane mask in little-endian order.
  word_t    le_wdata;     // Store data shifted into its lanes.
  logic     ld_pend_q;    // A load is waiting for its read data.
  logic     st_done_q;
  logic     misaligned_q;
  logic     busy_q;
  load_t    ld_type_q;    // Load flavour kept for the extender.
  byte_en_t ld_be_q;      // Lane mask kept for the extender.

  // ############################
  // Request decode.
  // ############################

  // A load wins if both requests show up together.
  always_comb begin
    is_half = 1'b0;
    is_word = 1'b0;
    if (ld_req) begin
      is_half = (load_type == LH) || (load_type == LHU);
      is_word = (load_type == LW);
    end else begin
      is_half = (store_type == SH);
      is_word = (store_type == SW);
    end
  end

  // Halves need bit 0 clear and words need both low bits clear.
  assign bad_align = (is_half && addr[0]) || (is_word && (addr[1:0] != 2'b00));
  assign accept    = (ld_req || st_req) && !bad_align;

  // Lanes counted from the byte at the lowest address.
  assign le_be = is_word ? 4'b1111 :
                 is_half ? byte_en_t'(4'b0011 << addr[1:0]) :
                           byte_en_t'(4'b0001 << addr[1:0]);

  // Move the low byte or half of the source into the addressed lane.
  assign le_wdata = is_word ? store_data :
                    is_half ? word_t'(store_data[15:0]) << {addr[1:0], 3'b000} :
                              word_t'(store_data[7:0]) << {addr[1:0], 3'b000};

  // ############################
  // Memory side, big-endian.
  // ############################

  assign data_req   = accept;         // One pulse per accepted access.
  assign data_addr  = addr;
  assign data_we    = accept && !ld_req; // Stores only when no load competes.
  assign data_be    = {le_be[0], le_be[1], le_be[2], le_be[3]};
  assign data_wdata = {le_wdata[7:0], le_wdata[15:8], le_wdata[23:16], le_wdata[31:24]};

  // ############################
  // Completion tracking.
  // ############################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ld_pend_q    <= 1'b0;
      st_done_q    <= 1'b0;
      misaligned_q <= 1'b0;
      busy_q       <= 1'b0;
    end else begin
      ld_pend_q    <= accept && ld_req && data_gnt;
      st_done_q    <= accept && !ld_req && data_gnt;
      misaligned_q <= (ld_req || st_req) && bad_align; // Flag instead of a done strobe.
      busy_q       <= ld_req || st_req;                // Covers the completion cycle.
    end
  end

  // Load type and lane mask ride along with the pending load for the extender.
  always_ff @(posedge clk) begin
    if (accept && ld_req) begin
      ld_type_q <= load_type;
      ld_be_q   <= le_be;
    end
  end

  dmem_extender u_dmem_extender (
    .dmem_in   (ram_rdata),
    .load_type (ld_type_q),
    .byte_en   (ld_be_q),
    .ext_out   (ld_data)
  );

  assign ld_done    = ld_pend_q && data_rvalid; // Read data belongs to this load.
  assign st_done    = st_done_q;
  assign misaligned = misaligned_q;
  assign busy       = busy_q;

endmodule

`default_nettype wire

// ==== hdl/dmem_extender.sv ====
// Load data formatter: byte swap to little-endian, lane slice, sign or zero extension.
`default_nettype none

module dmem_extender import rv32i_mem_pkg::*; (
  input  word_t    dmem_in,   // Word straight from the RAM, big-endian.
  input  load_t    load_type, // Which load produced this word.
  input  byte_en_t byte_en,   // Little-endian lane mask of the access.
  output word_t    ext_out    // Value for the destination register.
);

  word_t le_word; // RAM word with bytes back in little-endian order.

  // The RAM keeps byte 0 in the top lane, so flip all four lanes.
  assign le_word = {dmem_in[7:0], dmem_in[15:8], dmem_in[23:16], dmem_in[31:24]};

  always_comb begin
    ext_out = '0; // Unknown types and odd lane patterns read as zero.
    case (load_type)
      LB, LBU: begin
        // Pick the single enabled byte, then extend per the load flavour.
        case (byte_en)
          4'b0001: ext_out = {24'h0, le_word[7:0]};
          4'b0010: ext_out = {24'h0, le_word[15:8]};
          4'b0100: ext_out = {24'h0, le_word[23:16]};
          4'b1000: ext_out = {24'h0, le_word[31:24]};
          default: ext_out = '0;
        endcase
        if (load_type == LB) begin
          ext_out[31:8] = {24{ext_out[7]}}; // Replicate the byte's sign bit.
        end
      end
      LH, LHU: begin
        // Only the low or the high half is legal.
        case (byte_en)
          4'b0011: ext_out = {16'h0, le_word[15:0]};
          4'b1100: ext_out = {16'h0, le_word[31:16]};
          default: ext_out = '0;
        endcase
        if (load_type == LH) begin
          ext_out[31:16] = {16{ext_out[15]}}; // Replicate the half's sign bit.
        end
      end
      LW: begin
        ext_out = le_word; // Whole word, no slicing needed.
      end
      default: begin
        ext_out = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/rv32i_mem_pkg.sv ====
// Word, address and lane types, load and store enums, RAM sizing and reset vector.
`default_nettype none

package rv32i_mem_pkg;

  // ############################
  // Data path types.
  // ############################

  typedef logic [31:0] word_t;    // One 32-bit data word.
  typedef logic [31:0] addr_t;    // Byte address as seen by the core.
  typedef logic [3:0]  byte_en_t; // Bit i selects byte i of a word.

  // ############################
  // Access kinds.
  // ############################

  // Load flavours of RV32I. Signed and unsigned variants share a width.
  typedef enum logic [2:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW
  } load_t;

  // Store flavours of RV32I. Stores never extend, so there are only three.
  typedef enum logic [1:0] {
    SB,
    SH,
    SW
  } store_t;

  // ############################
  // Memory map.
  // ############################

  // The RAM holds 256 words, so it decodes address bits 9 down to 2.
  localparam int unsigned RAM_WORDS = 256;
  localparam int unsigned RAM_IDX_W = 8;

  // First address fetched after reset.
  localparam addr_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire
